//--- design/lcd_byte_shifter.sv
// SPI byte serialiser with spi_clk at half clk and gated between bytes
// drives spi_clk, spi_mosi, spi_dc and spi_csn, pulses byte_done at the end
`timescale 1ns/1ps
`default_nettype none

module lcd_byte_shifter
  import lcd_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      load,       // start a byte, one cycle pulse
  input  spi_byte_t tx,
  output logic      byte_done,  // first idle cycle after a byte
  output logic      spi_clk,
  output logic      spi_mosi,
  output logic      spi_dc,
  output logic      spi_csn
);

  logic       busy;
  logic [3:0] phase;     // 16 half-bit cycles per byte
  byte_t      shreg;
  logic       dc_q;
  logic       clk_int;   // internal phase clock, idles high

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      phase     <= '0;
      byte_done <= 1'b0;
      dc_q      <= 1'b0;
    end else begin
      byte_done <= 1'b0;
      if (load && !busy) begin
        busy  <= 1'b1;
        phase <= '0;
        dc_q  <= tx.dc;  // held for the whole byte
      end else if (busy) begin
        phase <= phase + 1'b1;
        if (phase == 4'd15) begin
          busy      <= 1'b0;
          byte_done <= 1'b1;
        end
      end
    end
  end

  // next payload bit moves up on the falling spi_clk edge
  always_ff @(posedge clk) begin
    if (load && !busy) begin
      shreg <= tx.data;
    end else if (busy && phase[0]) begin
      shreg <= {shreg[6:0], 1'b0};
    end
  end

  assign clk_int  = ~busy | ~phase[0];           // low in odd half-bits
  assign spi_clk  = clk_int ^ lcd_clk_polarity;   // rises mid-bit
  assign spi_mosi = busy & shreg[7];              // 0 while idle
  assign spi_dc   = dc_q;
  assign spi_csn  = ~busy;                        // high whenever clock stopped

endmodule

`default_nettype wire

//--- design/lcd_delay_timer.sv
// down-counter for panel reset hold and script delays
// done stays high as a level whenever the count sits at zero
`timescale 1ns/1ps
`default_nettype none

module lcd_delay_timer
  import lcd_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   start,  // load count, one cycle pulse
  input  delay_t count,  // cycles to wait
  output logic   done
);

  delay_t cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;  // idle, done high
    end else if (start) begin
      cnt <= count;
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;  // stops at zero
    end
  end

  assign done = (cnt == '0);

endmodule

`default_nettype wire

//--- design/lcd_init.mem
// init script, one entry per line
// columns: command, count (bit 7 delay flag, bits 4:0 args), args, delay exponent
01 80 03
B2 05 0C 0C 00 33 33
E0 0E D0 04 0D 11 13 2B 3F 54 4C 18 0D 0B 1F 23

//--- design/lcd_init_rom.sv
// init script memory loaded from the hex file
// one cycle registered read
`timescale 1ns/1ps
`default_nettype none

module lcd_init_rom
  import lcd_pkg::*;
(
  input  logic      clk,
  input  rom_addr_t addr,
  output byte_t     data
);

  byte_t mem [0:lcd_init_size-1];  // cmd, count, args, delay ...

  initial begin
    $readmemh(lcd_init_file, mem);
  end

  // addresses past the script read back as zero
  always_ff @(posedge clk) begin
    if (addr < rom_addr_t'(lcd_init_size)) begin
      data <= mem[addr[$clog2(lcd_init_size)-1:0]];  // upper bits zero in range
    end else begin
      data <= '0;
    end
  end

endmodule

`default_nettype wire

//--- design/lcd_pixel_scan.sv
// x/y raster counters for the pixel stream
// next_pixel marks the cycle in which x/y change
`timescale 1ns/1ps
`default_nettype none

module lcd_pixel_scan
  import lcd_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic advance,     // low pixel byte loaded
  output x_t   x,
  output y_t   y,
  output logic next_pixel
);

  always_ff @(posedge clk) begin
    if (reset) begin
      x          <= '0;
      y          <= '0;
      next_pixel <= 1'b0;
    end else begin
      next_pixel <= advance;  // aligned with x/y update
      if (advance) begin
        if (x == x_t'(lcd_x_size - 1)) begin
          x <= '0;  // end of line
          if (y == y_t'(lcd_y_size - 1)) begin
            y <= '0;  // end of frame
          end else begin
            y <= y + 1'b1;
          end
        end else begin
          x <= x + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/lcd_pkg.sv
// shared widths, screen and timing constants for the SPI display driver
// sequencer state encoding and the byte struct passed to the shifter
`default_nettype none

package lcd_pkg;

  // meaningful widths
  typedef logic [7:0]  byte_t;      // one SPI byte
  typedef logic [15:0] color_t;     // RGB565 pixel
  typedef logic [3:0]  x_t;         // column
  typedef logic [2:0]  y_t;         // row
  typedef logic [5:0]  rom_addr_t;  // init script address
  typedef logic [19:0] delay_t;     // delay in clk cycles

  // screen size kept small for simulation
  localparam int lcd_x_size = 16;
  localparam int lcd_y_size = 8;

  // init script
  localparam int    lcd_init_size = 26;                   // bytes in script
  localparam string lcd_init_file = "design/lcd_init.mem"; // relative to run dir

  // timing
  localparam int lcd_clk_per_us = 4;   // clk cycles per microsecond
  localparam int lcd_reset_us   = 16;  // panel reset hold

  // spi_clk idles low as on st7789 and runs inverted to the internal phase
  localparam bit lcd_clk_polarity = 1'b1;

  typedef enum logic [2:0] {
    st_reset_hold,  // panel reset via timer
    st_cmd,         // command byte, dc=0
    st_count,       // delay flag and arg count
    st_arg,         // argument bytes, dc=1
    st_delay,       // 2^n us pause, nothing sent
    st_pix_hi,      // colour high byte
    st_pix_lo       // colour low byte
  } seq_state_t;

  typedef struct packed {
    byte_t data;  // msb goes out first
    logic  dc;    // 0 command, 1 data
  } spi_byte_t;

endpackage

`default_nettype wire

//--- design/lcd_sequencer.sv
// FSM that holds panel reset, replays the init script, then streams pixels
// drives the byte shifter, delay timer and script ROM address
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer
  import lcd_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  output rom_addr_t rom_addr,
  input  byte_t     rom_data,     // one cycle after rom_addr
  output logic      delay_start,
  output delay_t    delay_count,
  input  logic      delay_done,
  output logic      load,
  output spi_byte_t tx,
  input  logic      byte_done,
  input  color_t    color,
  output logic      advance,      // low pixel byte loaded
  output logic      spi_resn
);

  seq_state_t state, state_nxt;
  rom_addr_t  idx;        // current script byte
  logic       rd_ok;      // rom_data matches idx
  logic       step;       // move to next script byte
  logic       idle_q;     // shifter finished, no load since
  logic       ready;      // a load may go out this cycle
  logic       wait_q;     // timer armed
  logic [4:0] args_left;
  logic       has_delay;
  byte_t      color_lo;   // low byte of sampled colour

  assign ready    = idle_q | byte_done;
  assign rom_addr = idx;

  always_comb begin
    state_nxt   = state;
    load        = 1'b0;
    step        = 1'b0;
    delay_start = 1'b0;
    advance     = 1'b0;
    delay_count = delay_t'(lcd_reset_us * lcd_clk_per_us);
    tx.data     = rom_data;
    tx.dc       = 1'b1;
    case (state)
      st_reset_hold: begin
        delay_start = ~wait_q;  // arm once
        if (wait_q && delay_done) state_nxt = st_cmd;
      end
      st_cmd: begin
        tx.dc = 1'b0;
        if (idx == rom_addr_t'(lcd_init_size)) begin
          state_nxt = st_pix_hi;  // script finished
        end else if (rd_ok && ready) begin
          load      = 1'b1;
          step      = 1'b1;
          state_nxt = st_count;
        end
      end
      st_count: begin
        if (rd_ok) begin
          step = 1'b1;  // count byte itself is not sent
          if (rom_data[4:0] != 5'd0) state_nxt = st_arg;
          else if (rom_data[7])      state_nxt = st_delay;
          else                       state_nxt = st_cmd;
        end
      end
      st_arg: begin
        if (rd_ok && ready) begin
          load = 1'b1;
          step = 1'b1;
          if (args_left == 5'd1) state_nxt = has_delay ? st_delay : st_cmd;
        end
      end
      st_delay: begin
        delay_count = delay_t'(lcd_clk_per_us) << rom_data[4:0];  // 2^n us
        if (!wait_q) begin
          delay_start = rd_ok && ready;  // last byte must be out first
          step        = delay_start;
        end else if (delay_done) begin
          state_nxt = st_cmd;
        end
      end
      st_pix_hi: begin
        tx.data = color[15:8];
        load    = ready;
        if (ready) state_nxt = st_pix_lo;
      end
      st_pix_lo: begin
        tx.data = color_lo;
        load    = ready;
        advance = ready;
        if (ready) state_nxt = st_pix_hi;
      end
      default: state_nxt = st_reset_hold;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_reset_hold;
      idx       <= '0;
      rd_ok     <= 1'b0;
      idle_q    <= 1'b1;  // shifter idle after reset
      wait_q    <= 1'b0;
      args_left <= '0;
      has_delay <= 1'b0;
      spi_resn  <= 1'b0;  // panel held in reset
    end else begin
      state  <= state_nxt;
      rd_ok  <= ~step;    // rom needs a cycle after addr moves
      idle_q <= (idle_q | byte_done) & ~load;
      if (step) idx <= idx + 1'b1;
      if (delay_start) begin
        wait_q <= 1'b1;
      end else if (delay_done) begin
        wait_q <= 1'b0;
      end
      if (state == st_reset_hold && state_nxt == st_cmd) spi_resn <= 1'b1;
      if (state == st_count && step) begin
        args_left <= rom_data[4:0];
        has_delay <= rom_data[7];
      end else if (state == st_arg && load) begin
        args_left <= args_left - 1'b1;
      end
    end
  end

  // low byte comes from the same colour sample as the high byte
  always_ff @(posedge clk) begin
    if (state == st_pix_hi && load) color_lo <= color[7:0];
  end

endmodule

`default_nettype wire

//--- design/lcd_video.sv
// SPI colour display driver top level
// script ROM, sequencer, delay timer, byte shifter and x/y scan
`timescale 1ns/1ps
`default_nettype none

module lcd_video
  import lcd_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  color_t color,       // valid for current x/y
  output x_t     x,
  output y_t     y,
  output logic   next_pixel,  // x/y just changed
  output logic   spi_csn,
  output logic   spi_clk,
  output logic   spi_mosi,
  output logic   spi_dc,
  output logic   spi_resn
);

  rom_addr_t rom_addr;
  byte_t     rom_data;
  logic      delay_start;
  delay_t    delay_count;
  logic      delay_done;
  logic      load;
  spi_byte_t tx;
  logic      byte_done;
  logic      advance;

  lcd_init_rom u_rom (
    .clk  (clk),
    .addr (rom_addr),
    .data (rom_data)
  );

  lcd_sequencer u_seq (
    .clk         (clk),
    .reset       (reset),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .delay_start (delay_start),
    .delay_count (delay_count),
    .delay_done  (delay_done),
    .load        (load),
    .tx          (tx),
    .byte_done   (byte_done),
    .color       (color),
    .advance     (advance),
    .spi_resn    (spi_resn)
  );

  lcd_delay_timer u_timer (
    .clk   (clk),
    .reset (reset),
    .start (delay_start),
    .count (delay_count),
    .done  (delay_done)
  );

  lcd_byte_shifter u_shift (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .tx        (tx),
    .byte_done (byte_done),
    .spi_clk   (spi_clk),
    .spi_mosi  (spi_mosi),
    .spi_dc    (spi_dc),
    .spi_csn   (spi_csn)
  );

  lcd_pixel_scan u_scan (
    .clk        (clk),
    .reset      (reset),
    .advance    (advance),
    .x          (x),
    .y          (y),
    .next_pixel (next_pixel)
  );

endmodule

`default_nettype wire

//--- lcd_video.f
+incdir+verification
design/lcd_pkg.sv
design/lcd_init_rom.sv
design/lcd_delay_timer.sv
design/lcd_byte_shifter.sv
design/lcd_pixel_scan.sv
design/lcd_sequencer.sv
design/lcd_video.sv
verification/lcd_video_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the lcd_video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f lcd_video.f --top-module lcd_video_tb \
  --Mdir obj_dir -o lcd_video_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/lcd_video_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- verification/lcd_tb_model.svh
// reference model for the display driver testbench
// script copy, expected init byte with dc and csn gap, colour pattern
`ifndef LCD_TB_MODEL_SVH
`define LCD_TB_MODEL_SVH

// same entries as the ROM image
byte_t script [0:lcd_init_size-1] = '{
  8'h01, 8'h80, 8'h03,                                     // swreset then 2^3 us
  8'hB2, 8'h05, 8'h0C, 8'h0C, 8'h00, 8'h33, 8'h33,         // porch control
  8'hE0, 8'h0E, 8'hD0, 8'h04, 8'h0D, 8'h11, 8'h13, 8'h2B,  // positive gamma
  8'h3F, 8'h54, 8'h4C, 8'h18, 8'h0D, 8'h0B, 8'h1F, 8'h23
};

// k-th init byte on the wire with its dc and the csn gap owed before it
function automatic bit script_entry(input int k, output byte_t data, output logic dc,
                                    output int min_gap);
  int a;
  int sent;
  int nargs;
  int pend;  // csn high cycles owed before the next command
  a       = 0;
  sent    = 0;
  pend    = 1;
  data    = '0;
  dc      = 1'b0;
  min_gap = 1;
  while (a < lcd_init_size) begin
    nargs = int'(script[a+1][4:0]);
    for (int i = 0; i <= nargs; i++) begin
      if (sent == k) begin
        data    = (i == 0) ? script[a] : script[a + 1 + i];
        dc      = (i != 0);           // command 0, argument 1
        min_gap = (i == 0) ? pend : 1;
        return 1'b1;
      end
      sent++;
    end
    pend = script[a+1][7] ? (lcd_clk_per_us << script[a + 2 + nargs]) : 1;  // 2^n us
    a    = a + 2 + nargs + int'(script[a+1][7]);
  end
  return 1'b0;
endfunction

// pattern that changes with x, y and frame
function automatic color_t color_of(input x_t x, input y_t y, input int frame);
  return {x, y, 1'b1, x ^ 4'(frame), 1'b0, y} ^ color_t'(frame * 16'h3b17);
endfunction

`endif

//--- verification/lcd_video_tb.sv
// testbench for the SPI display driver
// clock, reset, colour drive, SPI decoder, reference comparison and report
`timescale 1ns/1ps
`default_nettype none

module lcd_video_tb
  import lcd_pkg::*;
();

  `include "lcd_tb_model.svh"

  logic        clk   = 1'b0;
  logic        reset = 1'b1;
  color_t      color = '0;
  x_t          x;
  y_t          y;
  logic        next_pixel, spi_csn, spi_clk, spi_mosi, spi_dc, spi_resn;
  int unsigned seed;
  int          run = 0;          // 1 after the mid-run reset
  int          init_total;       // init bytes on the wire
  int          nbytes = 0;       // bytes decoded since reset
  int          npix = 0;         // next_pixel pulses since reset
  int          bitcnt = 0;
  int          gap = 0;          // csn high cycles since last byte
  byte_t       shreg = '0;
  logic        byte_strobe = 1'b0;
  logic [8:0]  got = '0;         // {dc, data}
  int          got_gap = 0;
  logic [8:0]  run_log [0:1023]; // first pass stream
  int          run_len = 0;
  int          err_hold = 0, err_init = 0, err_gap = 0, err_pix = 0, err_scan = 0, err_rep = 0;
  int          errs_before;
  int          passed = 0;
  int          failed = 0;

  lcd_video u_dut (
    .clk        (clk),
    .reset      (reset),
    .color      (color),
    .x          (x),
    .y          (y),
    .next_pixel (next_pixel),
    .spi_csn    (spi_csn),
    .spi_clk    (spi_clk),
    .spi_mosi   (spi_mosi),
    .spi_dc     (spi_dc),
    .spi_resn   (spi_resn)
  );

  always #2 clk = ~clk;  // 4 ns period

  // SPI decoder samples mid spi_clk pulse on the falling clk edge
  always @(negedge clk) begin
    byte_strobe <= 1'b0;
    if (reset) begin
      bitcnt <= 0;
      gap    <= 0;
    end else if (spi_csn) begin
      gap <= gap + 1;  // idle run before next byte
    end else if (spi_clk) begin
      shreg  <= {shreg[6:0], spi_mosi};  // msb first
      bitcnt <= (bitcnt == 7) ? 0 : bitcnt + 1;
      if (bitcnt == 7) begin
        got         <= {spi_dc, shreg[6:0], spi_mosi};
        got_gap     <= gap;
        gap         <= 0;
        byte_strobe <= 1'b1;
      end
    end
  end

  // comparison against the model
  always @(posedge clk) begin
    if (reset) begin
      nbytes <= 0;
    end else if (byte_strobe) begin
      check_byte(nbytes, got, got_gap);
      nbytes <= nbytes + 1;
    end
  end

  // raster check and colour drive
  always @(negedge clk) begin
    if (reset) begin
      npix = 0;
    end else if (next_pixel) begin
      npix = npix + 1;
      if (x !== x_t'(npix % lcd_x_size)) begin
        $display("[FAIL] %0t x got %0d expected %0d", $time, x, npix % lcd_x_size);
        err_scan++;
      end
      if (y !== y_t'((npix / lcd_x_size) % lcd_y_size)) begin
        $display("[FAIL] %0t y got %0d expected %0d", $time, y,
                 (npix / lcd_x_size) % lcd_y_size);
        err_scan++;
      end
    end
    color <= color_of(x, y, npix / (lcd_x_size * lcd_y_size));  // frame count
  end

  task automatic check_byte(input int k, input logic [8:0] b, input int g);
    byte_t  exp_data;
    logic   exp_dc;
    int     min_gap;
    int     n;
    color_t c;
    if (k < init_total) begin
      void'(script_entry(k, exp_data, exp_dc, min_gap));
      if (b[7:0] !== exp_data || b[8] !== exp_dc) begin
        $display("[FAIL] %0t spi_mosi/spi_dc byte %0d got %02h/%0b expected %02h/%0b",
                 $time, k, b[7:0], b[8], exp_data, exp_dc);
        err_init++;
      end
    end else begin
      n        = (k - init_total) / 2;  // pixel index since init
      min_gap  = 1;
      c        = color_of(x_t'(n % lcd_x_size), y_t'((n / lcd_x_size) % lcd_y_size),
                          n / (lcd_x_size * lcd_y_size));
      exp_data = ((k - init_total) % 2 == 0) ? c[15:8] : c[7:0];  // hi then lo
      if (b[7:0] !== exp_data || b[8] !== 1'b1) begin
        $display("[FAIL] %0t spi_mosi/spi_dc pixel byte %0d got %02h/%0b expected %02h/1",
                 $time, k - init_total, b[7:0], b[8], exp_data);
        err_pix++;
      end
    end
    if (k > 0 && g < min_gap) begin
      $display("[FAIL] %0t spi_csn gap before byte %0d got %0d expected >= %0d",
               $time, k, g, min_gap);
      err_gap++;
    end
    if (run == 0 && k < 1024) begin
      run_log[k] = b;
      run_len    = k + 1;
    end else if (run == 1 && k < run_len && b !== run_log[k]) begin
      $display("[FAIL] %0t spi_dc/spi_mosi stream byte %0d got %03h expected %03h",
               $time, k, b, run_log[k]);
      err_rep++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset <= 1'b1;
    repeat (10) @(negedge clk);
    reset <= 1'b0;
  endtask

  task automatic check_reset_hold();
    int   n;
    logic idle_clk;
    n        = 0;
    idle_clk = ~lcd_clk_polarity;  // inverted polarity idles low
    if (spi_resn !== 1'b0) begin
      $display("[FAIL] %0t spi_resn got %0b expected 0", $time, spi_resn);
      err_hold++;
    end
    if (spi_csn !== 1'b1) begin
      $display("[FAIL] %0t spi_csn got %0b expected 1", $time, spi_csn);
      err_hold++;
    end
    if (next_pixel !== 1'b0) begin
      $display("[FAIL] %0t next_pixel got %0b expected 0", $time, next_pixel);
      err_hold++;
    end
    if (spi_clk !== idle_clk) begin
      $display("[FAIL] %0t spi_clk got %0b expected %0b", $time, spi_clk, idle_clk);
      err_hold++;
    end
    while (spi_resn !== 1'b1) begin
      @(negedge clk);
      n++;
      if (spi_csn !== 1'b1) begin
        $display("[FAIL] %0t spi_csn got %0b expected 1 while spi_resn low",
                 $time, spi_csn);
        err_hold++;
      end
      if (n > 1000) abort_run("spi_resn never went high");
    end
    if (n < lcd_reset_us * lcd_clk_per_us) begin
      $display("[FAIL] %0t spi_resn low cycles got %0d expected >= %0d", $time, n,
               lcd_reset_us * lcd_clk_per_us);
      err_hold++;
    end
  endtask

  task automatic wait_bytes(input int count, input int limit);
    int n;
    n = 0;
    while (nbytes < count) begin
      @(posedge clk);
      n++;
      if (n > limit) abort_run("init bytes did not arrive");
    end
  endtask

  task automatic wait_pixels(input int count, input int limit);
    int n;
    n = 0;
    while (npix < count) begin
      @(posedge clk);
      n++;
      if (n > limit) abort_run("next_pixel pulses did not arrive");
    end
  endtask

  task automatic report_test(input int id, input string name, input int errs);
    $display("test %0d %s: %s (%0d errors)", id, name, (errs == 0) ? "ok" : "bad", errs);
    if (errs == 0) passed++;
    else           failed++;
  endtask

  initial begin
    byte_t d;
    logic  dcv;
    int    mg;
    int    skip;
    seed       = $urandom(79);
    init_total = 0;
    while (script_entry(init_total, d, dcv, mg)) init_total++;
    apply_reset();
    check_reset_hold();
    wait_bytes(init_total, 5000);
    wait_pixels(2 * lcd_x_size * lcd_y_size, 20000);  // two frames
    @(negedge clk);
    report_test(1, "panel reset hold", err_hold);
    report_test(2, "init bytes and dc", err_init);
    report_test(3, "csn gaps and delay", err_gap);
    report_test(4, "pixel bytes", err_pix);
    report_test(5, "x/y raster", err_scan);
    skip = $urandom_range(300);
    repeat (skip) @(negedge clk);  // random point in the pixel stream
    errs_before = err_hold + err_init + err_gap + err_pix + err_scan;
    run = 1;
    apply_reset();
    check_reset_hold();
    wait_bytes(init_total, 5000);
    wait_pixels(32, 5000);
    @(negedge clk);
    report_test(6, "restart after mid-run reset",
                err_rep + err_hold + err_init + err_gap + err_pix + err_scan - errs_before);
    $display("tests: %0d passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
